/* Bender.yml */
package:
  name: debug_system

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dii_package.sv
      - verilog/dii_fifo.sv
      - verilog/osd_him.sv
      - verilog/osd_scm.sv
      - verilog/debug_system.sv
  - target: test
    include_dirs:
      - verilog
      - tests
    files:
      - tests/tb_debug_system.sv

/* debug_system.f */
+incdir+verilog
+incdir+tests
verilog/dii_package.sv
verilog/dii_fifo.sv
verilog/osd_him.sv
verilog/osd_scm.sv
verilog/debug_system.sv
tests/tb_debug_system.sv

/* tests/tb_debug_tasks.svh */
`ifndef TB_DEBUG_TASKS_SVH
`define TB_DEBUG_TASKS_SVH

// one host word, held on the bus until the DUT takes it.
task automatic push_word(input logic [15:0] word);
   logic taken;
   glip_in_data  = word;
   glip_in_valid = 1'b1;
   taken = 1'b0;
   while (!taken) begin
      @(negedge clk);
      taken = glip_in_ready;
      @(posedge clk);
      #2;
   end
   glip_in_valid = 1'b0;
endtask

task automatic make_request(input logic [9:0] dest, input dii_subtype_e subtype,
                            input logic [15:0] addr, input logic [15:0] data);
   dii_word_t tw;
   tw.raw                = '0;
   tw.type_word.pkt_type = REG;
   tw.type_word.subtype  = subtype;
   req_q.delete();
   req_q.push_back({6'b0, dest});
   req_q.push_back({6'b0, `DII_HOST_ID});
   req_q.push_back(tw.raw);
   req_q.push_back(addr);
   if (subtype == REQ_WRITE) begin
      req_q.push_back(data);
   end
endtask

task automatic send_host_packet();
   int n;
   n = req_q.size();
   push_word(16'(n));
   for (int i = 0; i < n; i++) begin
      push_word(req_q[i]);
   end
endtask

// length word first, then as many words as it announces.
task automatic recv_host_packet(input logic random_bp);
   logic [31:0] rnd;
   logic [15:0] remaining;
   logic        have_len;
   have_len  = 1'b0;
   remaining = 16'd1;
   resp_q.delete();
   while (remaining != 16'd0) begin
      if (random_bp) begin
         rnd = $random(seed);
         glip_out_ready = rnd[0];
      end else begin
         glip_out_ready = 1'b1;
      end
      @(negedge clk);
      if (glip_out_valid && glip_out_ready) begin
         if (!have_len) begin
            resp_len  = glip_out_data;
            remaining = glip_out_data;
            have_len  = 1'b1;
         end else begin
            resp_q.push_back(glip_out_data);
            remaining = remaining - 16'd1;
         end
      end
      @(posedge clk);
      #2;
   end
   glip_out_ready = 1'b0;
endtask

task automatic check_len(input string name, input logic [15:0] got, input logic [15:0] exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
   end
endtask

task automatic check_word(input string name, input dii_word_t got, input dii_word_t exp);
   checks++;
   if (got.type_word.pkt_type !== exp.type_word.pkt_type ||
       got.type_word.subtype !== exp.type_word.subtype ||
       got.type_word.reserved !== exp.type_word.reserved) begin
      errors++;
      $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got.raw, exp.raw);
   end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
   end
endtask

task automatic check_ctrl(input logic exp_sys, input logic exp_cpu);
   check_flag("sys_rst", sys_rst, exp_sys);
   check_flag("cpu_rst", cpu_rst, exp_cpu);
endtask

// response from the control module back to the host.
task automatic check_response(input dii_subtype_e exp_sub, input logic has_data,
                              input logic [15:0] exp_data);
   dii_word_t   got_w;
   dii_word_t   exp_w;
   logic [15:0] exp_len;
   exp_len = has_data ? 16'd4 : 16'd3;
   check_len("glip_out_data length word", resp_len, exp_len);
   if (resp_len == exp_len) begin
      got_w.raw = resp_q[0];
      exp_w.raw = {6'b0, `DII_HOST_ID};
      check_word("glip_out_data destination word", got_w, exp_w);
      got_w.raw = resp_q[1];
      exp_w.raw = {6'b0, `SCM_ID};
      check_word("glip_out_data source word", got_w, exp_w);
      got_w.raw                = resp_q[2];
      exp_w.raw                = '0;
      exp_w.type_word.pkt_type = REG;
      exp_w.type_word.subtype  = exp_sub;
      check_word("glip_out_data type word", got_w, exp_w);
      if (has_data) begin
         got_w.raw = resp_q[3];
         exp_w.raw = exp_data;
         check_word("glip_out_data data word", got_w, exp_w);
      end
   end
endtask

`endif

/* tests/tb_debug_system.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dii_macros.svh"

module tb_debug_system;
   import dii_package::*;

   // roughly ten times what the tests need.
   localparam int MAX_CYCLES = 4000;

   logic        clk;
   logic        rst_n;
   logic [15:0] glip_in_data;
   logic        glip_in_valid;
   logic        glip_in_ready;
   logic [15:0] glip_out_data;
   logic        glip_out_valid;
   logic        glip_out_ready;
   logic        sys_rst;
   logic        cpu_rst;

   logic [15:0] req_q [$];
   logic [15:0] resp_q [$];
   logic [15:0] resp_len;
   integer      seed;
   int          cycles;
   int          checks;
   int          errors;

   debug_system u_dut (
      .clk            (clk),
      .rst_n          (rst_n),
      .glip_in_data   (glip_in_data),
      .glip_in_valid  (glip_in_valid),
      .glip_in_ready  (glip_in_ready),
      .glip_out_data  (glip_out_data),
      .glip_out_valid (glip_out_valid),
      .glip_out_ready (glip_out_ready),
      .sys_rst        (sys_rst),
      .cpu_rst        (cpu_rst)
   );

   `include "tb_debug_tasks.svh"

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

   task automatic test_reset_state();
      check_flag("glip_out_valid", glip_out_valid, 1'b0);
      check_ctrl(1'b0, 1'b0);
   endtask

   task automatic test_read_system_id();
      make_request(`SCM_ID, REQ_READ, `SCM_ADDR_SYSTEM_ID, 16'h0000);
      send_host_packet();
      recv_host_packet(1'b0);
      check_response(RESP_READ_OK, 1'b1, 16'hdead);
   endtask

   task automatic test_read_mod_type();
      make_request(`SCM_ID, REQ_READ, `SCM_ADDR_MOD_TYPE, 16'h0000);
      send_host_packet();
      recv_host_packet(1'b0);
      check_response(RESP_READ_OK, 1'b1, `SCM_MOD_TYPE);
   endtask

   task automatic test_control_write();
      make_request(`SCM_ID, REQ_WRITE, `SCM_ADDR_CONTROL, 16'h0003);
      send_host_packet();
      recv_host_packet(1'b0);
      check_response(RESP_WRITE_OK, 1'b0, 16'h0000);
      check_ctrl(1'b1, 1'b1);
      // control register reads back as {cpu_rst, sys_rst}.
      make_request(`SCM_ID, REQ_READ, `SCM_ADDR_CONTROL, 16'h0000);
      send_host_packet();
      recv_host_packet(1'b0);
      check_response(RESP_READ_OK, 1'b1, 16'h0003);
      make_request(`SCM_ID, REQ_WRITE, `SCM_ADDR_CONTROL, 16'h0000);
      send_host_packet();
      recv_host_packet(1'b0);
      check_response(RESP_WRITE_OK, 1'b0, 16'h0000);
      check_ctrl(1'b0, 1'b0);
   endtask

   task automatic test_unmapped_access();
      make_request(`SCM_ID, REQ_READ, 16'h0100, 16'h0000);
      send_host_packet();
      recv_host_packet(1'b0);
      check_response(RESP_READ_ERR, 1'b1, 16'h0000);
      make_request(`SCM_ID, REQ_WRITE, 16'h0100, 16'h0003);
      send_host_packet();
      recv_host_packet(1'b0);
      check_response(RESP_WRITE_ERR, 1'b0, 16'h0000);
      check_ctrl(1'b0, 1'b0);
   endtask

   // a foreign write would raise both resets if it were not dropped.
   task automatic test_drop_other_id();
      int stray;
      stray = 0;
      make_request(10'd5, REQ_WRITE, `SCM_ADDR_CONTROL, 16'h0003);
      send_host_packet();
      make_request(`SCM_ID, REQ_READ, `SCM_ADDR_SYSTEM_ID, 16'h0000);
      send_host_packet();
      recv_host_packet(1'b1);
      check_response(RESP_READ_OK, 1'b1, `SCM_SYSTEM_ID);
      check_ctrl(1'b0, 1'b0);
      repeat (20) begin
         @(negedge clk);
         if (glip_out_valid) begin
            stray++;
         end
      end
      @(posedge clk);
      #2;
      if (stray != 0) begin
         errors++;
         $display("an extra response appeared for the packet sent to id 5");
      end
   endtask

   initial begin
      seed           = 32'ha78fc0ad;
      checks         = 0;
      errors         = 0;
      rst_n          = 1'b0;
      glip_in_data   = '0;
      glip_in_valid  = 1'b0;
      glip_out_ready = 1'b0;
      resp_len       = '0;
      repeat (4) @(posedge clk);
      #2;
      rst_n = 1'b1;
      test_reset_state();
      test_read_system_id();
      test_read_mod_type();
      test_control_write();
      test_unmapped_access();
      test_drop_other_id();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/debug_system.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dii_macros.svh"

module debug_system (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] glip_in_data,
   input  logic        glip_in_valid,
   output logic        glip_in_ready,
   output logic [15:0] glip_out_data,
   output logic        glip_out_valid,
   input  logic        glip_out_ready,
   output logic        sys_rst,
   output logic        cpu_rst
);
   import dii_package::*;

   // request path, host interface to control module.
   dii_flit him_req;
   logic    him_req_ready;
   dii_flit scm_req;
   logic    scm_req_ready;

   // response path, control module back to host interface.
   dii_flit scm_resp;
   logic    scm_resp_ready;
   dii_flit him_resp;
   logic    him_resp_ready;

   osd_him u_him (
      .clk             (clk),
      .rst_n           (rst_n),
      .glip_in_data    (glip_in_data),
      .glip_in_valid   (glip_in_valid),
      .glip_in_ready   (glip_in_ready),
      .glip_out_data   (glip_out_data),
      .glip_out_valid  (glip_out_valid),
      .glip_out_ready  (glip_out_ready),
      .to_fifo         (him_req),
      .to_fifo_ready   (him_req_ready),
      .from_fifo       (him_resp),
      .from_fifo_ready (him_resp_ready)
   );

   dii_fifo #(.DEPTH(`DII_FIFO_DEPTH)) u_req_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_flit   (him_req),
      .in_ready  (him_req_ready),
      .out_flit  (scm_req),
      .out_ready (scm_req_ready)
   );

   osd_scm u_scm (
      .clk             (clk),
      .rst_n           (rst_n),
      .debug_in        (scm_req),
      .debug_in_ready  (scm_req_ready),
      .debug_out       (scm_resp),
      .debug_out_ready (scm_resp_ready),
      .sys_rst         (sys_rst),
      .cpu_rst         (cpu_rst)
   );

   dii_fifo #(.DEPTH(`DII_FIFO_DEPTH)) u_resp_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_flit   (scm_resp),
      .in_ready  (scm_resp_ready),
      .out_flit  (him_resp),
      .out_ready (him_resp_ready)
   );

endmodule

`default_nettype wire

/* verilog/dii_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dii_macros.svh"

module dii_fifo #(
   parameter int DEPTH = `DII_FIFO_DEPTH
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  dii_package::dii_flit in_flit,
   output logic                 in_ready,
   output dii_package::dii_flit out_flit,
   input  logic                 out_ready
);
   import dii_package::*;

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   dii_flit          mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             wr_en;
   logic             rd_en;

   assign in_ready = (count != CNT_W'(DEPTH));
   assign wr_en    = in_flit.valid && in_ready;
   assign rd_en    = out_flit.valid && out_ready;

   // head entry is visible as soon as it is counted.
   assign out_flit = '{valid: (count != '0), last: mem[rd_ptr].last, data: mem[rd_ptr].data};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= in_flit;
      end
   end

   // a flit refused while full must still be offered next cycle.
   a_full_hold: assert property (@(posedge clk) disable iff (!rst_n)
      in_flit.valid && !in_ready |=> in_flit.valid && $stable(in_flit.data));

   a_ptr_match: assert property (@(posedge clk) disable iff (!rst_n)
      (count == '0 || count == CNT_W'(DEPTH)) |-> wr_ptr == rd_ptr);

endmodule

`default_nettype wire

/* verilog/dii_macros.svh */
`ifndef DII_MACROS_SVH
`define DII_MACROS_SVH

// packet and buffer sizing.
`define DII_MAX_PKT_LEN 16
`define DII_FIFO_DEPTH 4

// debug ids on the interconnect.
`define DII_HOST_ID 10'd0
`define SCM_ID 10'd1

// system control module identification.
`define SCM_SYSTEM_ID 16'hdead
`define SCM_MOD_TYPE 16'h0001

// system control module register map.
`define SCM_ADDR_MOD_TYPE 16'h0000
`define SCM_ADDR_SYSTEM_ID 16'h0200
`define SCM_ADDR_CONTROL 16'h0203

`endif

/* verilog/dii_package.sv */
`default_nettype none

package dii_package;

   // one debug interconnect flit.
   typedef struct packed {
      logic        valid;
      logic        last;
      logic [15:0] data;
   } dii_flit;

   typedef enum logic [1:0] {
      REG   = 2'd0,
      EVENT = 2'd1
   } dii_type_e;

   typedef enum logic [3:0] {
      REQ_READ       = 4'd0,
      REQ_WRITE      = 4'd1,
      RESP_READ_OK   = 4'd2,
      RESP_READ_ERR  = 4'd3,
      RESP_WRITE_OK  = 4'd4,
      RESP_WRITE_ERR = 4'd5
   } dii_subtype_e;

   typedef struct packed {
      dii_type_e    pkt_type;
      dii_subtype_e subtype;
      logic [9:0]   reserved;
   } dii_type_word_t;

   // third flit of a packet, or any payload word.
   typedef union packed {
      logic [15:0]    raw;
      dii_type_word_t type_word;
   } dii_word_t;

endpackage

`default_nettype wire

/* verilog/osd_him.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dii_macros.svh"

module osd_him (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [15:0]          glip_in_data,
   input  logic                 glip_in_valid,
   output logic                 glip_in_ready,
   output logic [15:0]          glip_out_data,
   output logic                 glip_out_valid,
   input  logic                 glip_out_ready,
   output dii_package::dii_flit to_fifo,
   input  logic                 to_fifo_ready,
   input  dii_package::dii_flit from_fifo,
   output logic                 from_fifo_ready
);
   localparam int PTR_W = $clog2(`DII_MAX_PKT_LEN);
   localparam int CNT_W = PTR_W + 1;

   // host to flits.
   logic [CNT_W-1:0] in_cnt;
   logic             in_accept;
   logic             to_valid;
   logic             to_last;
   logic [15:0]      to_data;

   // flits to host.
   logic [15:0]      pkt_buf [`DII_MAX_PKT_LEN];
   logic [CNT_W-1:0] wr_cnt;
   logic [CNT_W-1:0] rd_idx;
   logic             sending;
   logic [15:0]      out_data;
   logic             flit_accept;
   logic             word_accept;

   // a length word is always taken, a flit word only when the output slot frees up.
   assign glip_in_ready = (in_cnt == '0) || !to_valid || to_fifo_ready;
   assign in_accept     = glip_in_valid && glip_in_ready;
   assign to_fifo       = '{valid: to_valid, last: to_last, data: to_data};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         in_cnt   <= '0;
         to_valid <= 1'b0;
         to_last  <= 1'b0;
      end else begin
         if (to_valid && to_fifo_ready) begin
            to_valid <= 1'b0;
            to_last  <= 1'b0;
         end
         if (in_accept) begin
            if (in_cnt == '0) begin
               in_cnt <= glip_in_data[CNT_W-1:0];
            end else begin
               in_cnt   <= in_cnt - 1'b1;
               to_valid <= 1'b1;
               to_last  <= (in_cnt == CNT_W'(1));
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in_accept && in_cnt != '0) begin
         to_data <= glip_in_data;
      end
   end

   assign from_fifo_ready = !sending;
   assign flit_accept     = from_fifo.valid && from_fifo_ready;
   assign word_accept     = sending && glip_out_ready;
   assign glip_out_valid  = sending;
   assign glip_out_data   = out_data;

   // rd_idx counts words already sent after the length word.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_cnt  <= '0;
         rd_idx  <= '0;
         sending <= 1'b0;
      end else if (!sending) begin
         if (flit_accept) begin
            wr_cnt <= wr_cnt + 1'b1;
            if (from_fifo.last) begin
               sending <= 1'b1;
               rd_idx  <= '0;
            end
         end
      end else if (word_accept) begin
         if (rd_idx == wr_cnt) begin
            sending <= 1'b0;
            wr_cnt  <= '0;
         end else begin
            rd_idx <= rd_idx + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (flit_accept) begin
         pkt_buf[wr_cnt[PTR_W-1:0]] <= from_fifo.data;
      end
      if (flit_accept && from_fifo.last) begin
         out_data <= 16'(wr_cnt + 1'b1);
      end else if (word_accept && rd_idx != wr_cnt) begin
         out_data <= pkt_buf[rd_idx[PTR_W-1:0]];
      end
   end

   a_len_range: assert property (@(posedge clk) disable iff (!rst_n)
      in_accept && in_cnt == '0 |->
         glip_in_data != '0 && glip_in_data <= `DII_MAX_PKT_LEN);

   a_buf_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
      flit_accept && !from_fifo.last |-> wr_cnt < CNT_W'(`DII_MAX_PKT_LEN - 1));

endmodule

`default_nettype wire

/* verilog/osd_scm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dii_macros.svh"

module osd_scm (
   input  logic                 clk,
   input  logic                 rst_n,
   input  dii_package::dii_flit debug_in,
   output logic                 debug_in_ready,
   output dii_package::dii_flit debug_out,
   input  logic                 debug_out_ready,
   output logic                 sys_rst,
   output logic                 cpu_rst
);
   import dii_package::*;

   typedef enum logic [2:0] {
      S_DEST, S_SRC, S_TYPE, S_ADDR, S_DATA, S_DROP, S_EXEC, S_RESP
   } state_e;

   state_e      state;
   logic        in_accept;
   dii_word_t   in_word;
   logic [15:0] dest_q;
   logic [15:0] src_q;
   dii_word_t   type_q;
   logic [15:0] addr_q;
   logic [15:0] wdata_q;
   logic        is_read;
   dii_word_t   resp_type;
   logic [15:0] resp_data;
   logic [1:0]  resp_idx;
   logic        out_valid;
   logic        out_last;
   logic [15:0] out_data;
   logic        out_accept;

   assign debug_in_ready = (state != S_EXEC) && (state != S_RESP);
   assign in_accept      = debug_in.valid && debug_in_ready;
   assign in_word.raw    = debug_in.data;
   assign is_read        = (type_q.type_word.subtype == REQ_READ);
   assign out_accept     = out_valid && debug_out_ready;
   assign debug_out      = '{valid: out_valid, last: out_last, data: out_data};

   always_comb begin
      resp_type.raw                = '0;
      resp_type.type_word.pkt_type = REG;
      resp_data                    = '0;
      if (is_read) begin
         resp_type.type_word.subtype = RESP_READ_OK;
         case (addr_q)
            `SCM_ADDR_MOD_TYPE:  resp_data = `SCM_MOD_TYPE;
            `SCM_ADDR_SYSTEM_ID: resp_data = `SCM_SYSTEM_ID;
            `SCM_ADDR_CONTROL:   resp_data = {14'b0, cpu_rst, sys_rst};
            default:             resp_type.type_word.subtype = RESP_READ_ERR;
         endcase
      end else if (addr_q == `SCM_ADDR_CONTROL) begin
         resp_type.type_word.subtype = RESP_WRITE_OK;
      end else begin
         resp_type.type_word.subtype = RESP_WRITE_ERR;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= S_DEST;
         sys_rst   <= 1'b0;
         cpu_rst   <= 1'b0;
         out_valid <= 1'b0;
         out_last  <= 1'b0;
         resp_idx  <= '0;
      end else begin
         case (state)
            S_DEST: if (in_accept && !debug_in.last) state <= S_SRC;
            S_SRC:  if (in_accept) state <= debug_in.last ? S_DEST : S_TYPE;
            S_TYPE: if (in_accept) begin
               if (debug_in.last) begin
                  state <= S_DEST;
               end else if (dest_q[9:0] != `SCM_ID ||
                            in_word.type_word.pkt_type != REG ||
                            (in_word.type_word.subtype != REQ_READ &&
                             in_word.type_word.subtype != REQ_WRITE)) begin
                  state <= S_DROP;
               end else begin
                  state <= S_ADDR;
               end
            end
            // a read ends at the address, a write one flit later.
            S_ADDR: if (in_accept) begin
               if (!debug_in.last) state <= S_DATA;
               else state <= is_read ? S_EXEC : S_DEST;
            end
            S_DATA: if (in_accept) begin
               if (!debug_in.last) state <= S_DROP;
               else state <= is_read ? S_DEST : S_EXEC;
            end
            S_DROP: if (in_accept && debug_in.last) state <= S_DEST;
            S_EXEC: begin
               if (!is_read && addr_q == `SCM_ADDR_CONTROL) begin
                  sys_rst <= wdata_q[0];
                  cpu_rst <= wdata_q[1];
               end
               out_valid <= 1'b1;
               out_last  <= 1'b0;
               resp_idx  <= 2'd1;
               state     <= S_RESP;
            end
            S_RESP: if (out_accept) begin
               if (out_last) begin
                  out_valid <= 1'b0;
                  out_last  <= 1'b0;
                  state     <= S_DEST;
               end else begin
                  resp_idx <= resp_idx + 1'b1;
                  out_last <= (resp_idx == 2'd3) || (resp_idx == 2'd2 && !is_read);
               end
            end
            default: state <= S_DEST;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (in_accept) begin
         case (state)
            S_DEST:  dest_q <= debug_in.data;
            S_SRC:   src_q <= debug_in.data;
            S_TYPE:  type_q <= in_word;
            S_ADDR:  addr_q <= debug_in.data;
            S_DATA:  wdata_q <= debug_in.data;
            default: ;
         endcase
      end
      // response goes back to the requester.
      if (state == S_EXEC) begin
         out_data <= src_q;
      end else if (out_accept && !out_last) begin
         case (resp_idx)
            2'd1:    out_data <= {6'b0, `SCM_ID};
            2'd2:    out_data <= resp_type.raw;
            default: out_data <= resp_data;
         endcase
      end
   end

   a_last_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
      debug_out.last |-> debug_out.valid);

endmodule

`default_nettype wire
